/* design/tlu_pkg.sv */
// shared definitions for the TLU controller
// register map, widths, trigger mode codes and the configuration byte layout
package tlu_pkg;

    localparam int BYTE_W = 8;   // register bus data width
    localparam int WORD_W = 32;  // fifo word, trigger number, timestamp

    // register map
    localparam int REG_SOFT_RST_VERSION = 0;  // write resets, read returns version
    localparam int REG_CONF             = 1;
    localparam int REG_TRIG_NUM_0       = 4;  // lowest byte first
    localparam int REG_TRIG_NUM_1       = 5;
    localparam int REG_TRIG_NUM_2       = 6;
    localparam int REG_TRIG_NUM_3       = 7;
    localparam int REG_TIMESTAMP_0      = 8;
    localparam int REG_TIMESTAMP_1      = 9;
    localparam int REG_TIMESTAMP_2      = 10;
    localparam int REG_TIMESTAMP_3      = 11;
    localparam int REG_LOST_CNT         = 12;

    localparam logic [BYTE_W-1:0] TLU_VERSION = 8'd1;

    // trigger modes, 2'b11 is handled like the simple handshake
    localparam logic [1:0] MODE_DISABLED         = 2'b00;
    localparam logic [1:0] MODE_NO_HANDSHAKE     = 2'b01;
    localparam logic [1:0] MODE_SIMPLE_HANDSHAKE = 2'b10;

    localparam logic WORD_MARKER = 1'b1;  // bit 31 of every fifo word

    // configuration fields, listed from bit 7 down to bit 0
    typedef struct packed {
        logic [1:0] spare;
        logic       write_timestamp;  // fifo word carries timestamp
        logic       enable_reset;     // trigger reset input clears counters
        logic       disable_veto;
        logic       invert_lemo;
        logic [1:0] tlu_mode;
    } tlu_conf_s;

    // bus sees the raw byte, the trigger logic sees the fields
    typedef union packed {
        logic [BYTE_W-1:0] raw;
        tlu_conf_s         field;
    } tlu_conf_u;

endpackage

/* design/tlu_regs.sv */
// TLU register file
// configuration byte, soft reset pulse and registered bus readback
`timescale 1ns/10ps

module tlu_regs #(
    parameter int ABUSWIDTH = 16
) (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic [ABUSWIDTH-1:0]       BUS_ADD,
    input  logic [tlu_pkg::BYTE_W-1:0] BUS_DATA_IN,
    input  logic                       BUS_WR,
    input  logic [tlu_pkg::WORD_W-1:0] trigger_number,
    input  logic [tlu_pkg::WORD_W-1:0] timestamp,
    input  logic [tlu_pkg::BYTE_W-1:0] lost_cnt,
    output logic [tlu_pkg::BYTE_W-1:0] BUS_DATA_OUT,
    output tlu_pkg::tlu_conf_u         conf,
    output logic                       soft_rst
);
    import tlu_pkg::*;

    logic wr_zero;    // write strobe on address 0
    logic wr_zero_q;

    assign wr_zero = BUS_WR && (BUS_ADD == ABUSWIDTH'(REG_SOFT_RST_VERSION));

    // one soft reset pulse per write burst to address 0
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_zero_q <= 1'b0;
            soft_rst  <= 1'b0;
        end
        else
        begin
            wr_zero_q <= wr_zero;
            soft_rst  <= wr_zero && !wr_zero_q;
        end
    end

    // configuration byte, cleared by soft reset as well
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            conf.raw <= '0;
        else if (BUS_WR && (BUS_ADD == ABUSWIDTH'(REG_CONF)))
            conf.raw <= BUS_DATA_IN;
    end

    // readback follows the address of the previous cycle
    always_ff @(posedge BUS_CLK)
    begin
        case (BUS_ADD)
            REG_SOFT_RST_VERSION:
                BUS_DATA_OUT <= TLU_VERSION;
            REG_CONF:
                BUS_DATA_OUT <= conf.raw;
            REG_TRIG_NUM_0:
                BUS_DATA_OUT <= trigger_number[7:0];
            REG_TRIG_NUM_1:
                BUS_DATA_OUT <= trigger_number[15:8];
            REG_TRIG_NUM_2:
                BUS_DATA_OUT <= trigger_number[23:16];
            REG_TRIG_NUM_3:
                BUS_DATA_OUT <= trigger_number[31:24];
            REG_TIMESTAMP_0:
                BUS_DATA_OUT <= timestamp[7:0];
            REG_TIMESTAMP_1:
                BUS_DATA_OUT <= timestamp[15:8];
            REG_TIMESTAMP_2:
                BUS_DATA_OUT <= timestamp[23:16];
            REG_TIMESTAMP_3:
                BUS_DATA_OUT <= timestamp[31:24];
            REG_LOST_CNT:
                BUS_DATA_OUT <= lost_cnt;
            default:
                BUS_DATA_OUT <= '0;  // unmapped
        endcase
    end

    // held writes to address 0 must still give a single-cycle reset
    a_soft_rst_single: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        soft_rst |=> !soft_rst
    ) else $error("soft reset high for more than one cycle");

endmodule

/* design/tlu_trigger_input.sv */
// TLU trigger input stage
// synchronizes RJ45 and LEMO inputs, picks the active connector, flags edges
`timescale 1ns/10ps

module tlu_trigger_input (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  logic               soft_rst,
    input  tlu_pkg::tlu_conf_u conf,
    input  logic               RJ45_TRIGGER,
    input  logic               LEMO_TRIGGER,
    input  logic               RJ45_RESET,
    input  logic               LEMO_RESET,
    output logic               RJ45_ENABLED,
    output logic               trigger_level,
    output logic               trigger_flag,
    output logic               reset_flag
);
    import tlu_pkg::*;

    logic       lemo_trig_mod;     // after optional inversion
    logic [3:0] sync_in;
    logic [3:0] sync_q [3];        // three stages, index 2 is the output
    logic       rj45_trig_s;
    logic       lemo_trig_s;
    logic       rj45_rst_s;
    logic       lemo_rst_s;
    logic       sel_trig;
    logic       sel_rst;
    logic       rst_level;

    assign lemo_trig_mod = conf.field.invert_lemo ? ~LEMO_TRIGGER : LEMO_TRIGGER;
    assign sync_in = {LEMO_RESET, RJ45_RESET, lemo_trig_mod, RJ45_TRIGGER};

    always_ff @(posedge BUS_CLK)
    begin
        sync_q[0] <= sync_in;
        sync_q[1] <= sync_q[0];
        sync_q[2] <= sync_q[1];
    end

    assign {lemo_rst_s, rj45_rst_s, lemo_trig_s, rj45_trig_s} = sync_q[2];

    // unplugged RJ45 reads both lines high
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            RJ45_ENABLED <= 1'b0;
        else if ((conf.field.tlu_mode == MODE_DISABLED) ||
                 (rj45_trig_s && rj45_rst_s && !RJ45_ENABLED))
            RJ45_ENABLED <= 1'b0;
        else
            RJ45_ENABLED <= 1'b1;
    end

    assign sel_trig = RJ45_ENABLED ? rj45_trig_s : lemo_trig_s;
    assign sel_rst  = RJ45_ENABLED ? rj45_rst_s : lemo_rst_s;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            trigger_level <= 1'b0;
            trigger_flag  <= 1'b0;
            rst_level     <= 1'b0;
            reset_flag    <= 1'b0;
        end
        else
        begin
            trigger_level <= sel_trig;
            trigger_flag  <= sel_trig && !trigger_level;  // rising edge
            rst_level     <= sel_rst;
            reset_flag    <= sel_rst && !rst_level && conf.field.enable_reset;
        end
    end

    a_flag_with_level: assert property (
        @(posedge BUS_CLK) trigger_flag |-> trigger_level
    ) else $error("trigger flag without trigger level");

endmodule

/* design/tlu_trigger_fsm.sv */
// TLU trigger acceptance FSM
// busy handshake, veto, trigger number and timestamp counters, fifo word build
`timescale 1ns/10ps

module tlu_trigger_fsm (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic                       soft_rst,
    input  tlu_pkg::tlu_conf_u         conf,
    input  logic                       trigger_level,
    input  logic                       trigger_flag,
    input  logic                       reset_flag,
    input  logic                       EXT_VETO,
    output logic                       TLU_BUSY,
    output logic                       fifo_write,
    output logic [tlu_pkg::WORD_W-1:0] fifo_word,
    output logic [tlu_pkg::WORD_W-1:0] trigger_number,
    output logic [tlu_pkg::WORD_W-1:0] timestamp
);
    import tlu_pkg::*;

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_BUSY = 1'b1;

    logic              rst_int;
    logic [2:0]        veto_sync;
    logic              veto_s;
    logic              state;
    logic              accept;
    logic              handshake;
    logic [WORD_W-2:0] word_payload;

    assign rst_int = RST || soft_rst;

    // veto is asynchronous to BUS_CLK
    always_ff @(posedge BUS_CLK)
    begin
        veto_sync <= {veto_sync[1:0], EXT_VETO};
    end

    assign veto_s = veto_sync[2];

    assign handshake = conf.field.tlu_mode[1];  // modes 10 and 11
    assign accept = (state == ST_IDLE) && trigger_flag &&
                    (conf.field.tlu_mode != MODE_DISABLED) &&
                    (!veto_s || conf.field.disable_veto);

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_int)
            state <= ST_IDLE;
        else if (state == ST_IDLE)
        begin
            if (accept && handshake)
                state <= ST_BUSY;
        end
        else if (!trigger_level)
            state <= ST_IDLE;  // trigger released
    end

    assign TLU_BUSY = (state == ST_BUSY);

    assign word_payload = conf.field.write_timestamp ? timestamp[WORD_W-2:0]
                                                     : trigger_number[WORD_W-2:0];

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_int)
            fifo_write <= 1'b0;
        else
            fifo_write <= accept;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            fifo_word <= {WORD_MARKER, word_payload};
    end

    // first accepted trigger carries number 0
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_int || reset_flag)
            trigger_number <= '0;
        else if (accept)
            trigger_number <= trigger_number + 1'b1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_int || reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;  // free running
    end

    a_no_busy_without_handshake: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        $rose(TLU_BUSY) |-> ($past(conf.field.tlu_mode) != MODE_NO_HANDSHAKE)
    ) else $error("busy raised in no-handshake mode");

endmodule

/* design/tlu_word_fifo.sv */
// TLU output FIFO
// circular buffer of trigger words, drops on full and counts lost words
`timescale 1ns/10ps

module tlu_word_fifo #(
    parameter int FIFO_DEPTH = 8  // power of two
) (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic                       soft_rst,
    input  logic                       fifo_write,
    input  logic [tlu_pkg::WORD_W-1:0] fifo_word,
    input  logic                       FIFO_READ,
    output logic                       FIFO_EMPTY,
    output logic [tlu_pkg::WORD_W-1:0] FIFO_DATA,
    output logic [tlu_pkg::BYTE_W-1:0] lost_cnt
);
    import tlu_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    fill;
    logic              full;
    logic              wr_en;
    logic              rd_en;

    assign full       = (fill == (PTR_W+1)'(FIFO_DEPTH));
    assign FIFO_EMPTY = (fill == '0);
    assign wr_en      = fifo_write && !full;
    assign rd_en      = FIFO_READ && !FIFO_EMPTY;
    assign FIFO_DATA  = mem[rd_ptr];  // head word

    always_ff @(posedge BUS_CLK)
    begin
        if (wr_en)
            mem[wr_ptr] <= fifo_word;
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + wr_en - rd_en;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            lost_cnt <= '0;
        else if (fifo_write && full && (lost_cnt != '1))
            lost_cnt <= lost_cnt + 1'b1;  // saturates at 255
    end

    a_fill_bound: assert property (
        @(posedge BUS_CLK) disable iff (RST)
        fill <= (PTR_W+1)'(FIFO_DEPTH)
    ) else $error("fifo fill count above depth");

endmodule

/* design/tlu_controller.sv */
// TLU interface controller top level
// register bus, trigger input stage, trigger FSM and output FIFO
`timescale 1ns/10ps

module tlu_controller #(
    parameter int ABUSWIDTH  = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic [ABUSWIDTH-1:0]       BUS_ADD,
    input  logic [tlu_pkg::BYTE_W-1:0] BUS_DATA_IN,
    input  logic                       BUS_WR,
    input  logic                       BUS_RD,      // reads decode from the address alone
    input  logic                       RJ45_TRIGGER,
    input  logic                       LEMO_TRIGGER,
    input  logic                       RJ45_RESET,
    input  logic                       LEMO_RESET,
    input  logic                       EXT_VETO,
    input  logic                       FIFO_READ,
    output logic [tlu_pkg::BYTE_W-1:0] BUS_DATA_OUT,
    output logic                       FIFO_EMPTY,
    output logic [tlu_pkg::WORD_W-1:0] FIFO_DATA,
    output logic                       RJ45_ENABLED,
    output logic                       TLU_BUSY
);
    import tlu_pkg::*;

    tlu_conf_u         conf;
    logic              soft_rst;
    logic              trigger_level;
    logic              trigger_flag;
    logic              reset_flag;
    logic              fifo_write;
    logic [WORD_W-1:0] fifo_word;
    logic [WORD_W-1:0] trigger_number;
    logic [WORD_W-1:0] timestamp;
    logic [BYTE_W-1:0] lost_cnt;

    tlu_regs #(.ABUSWIDTH(ABUSWIDTH)) regs0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR), .trigger_number(trigger_number), .timestamp(timestamp),
        .lost_cnt(lost_cnt), .BUS_DATA_OUT(BUS_DATA_OUT), .conf(conf), .soft_rst(soft_rst)
    );

    tlu_trigger_input input0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst), .conf(conf),
        .RJ45_TRIGGER(RJ45_TRIGGER), .LEMO_TRIGGER(LEMO_TRIGGER),
        .RJ45_RESET(RJ45_RESET), .LEMO_RESET(LEMO_RESET), .RJ45_ENABLED(RJ45_ENABLED),
        .trigger_level(trigger_level), .trigger_flag(trigger_flag), .reset_flag(reset_flag)
    );

    tlu_trigger_fsm fsm0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst), .conf(conf),
        .trigger_level(trigger_level), .trigger_flag(trigger_flag),
        .reset_flag(reset_flag), .EXT_VETO(EXT_VETO), .TLU_BUSY(TLU_BUSY),
        .fifo_write(fifo_write), .fifo_word(fifo_word),
        .trigger_number(trigger_number), .timestamp(timestamp)
    );

    tlu_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .soft_rst(soft_rst), .fifo_write(fifo_write),
        .fifo_word(fifo_word), .FIFO_READ(FIFO_READ), .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA), .lost_cnt(lost_cnt)
    );

endmodule

/* verification/tlu_controller_tb.sv */
// testbench for the TLU controller
// register access, trigger modes, veto, FIFO overflow and timestamp words
`timescale 1ns/10ps

module tlu_controller_tb;
    import tlu_pkg::*;

    localparam int ABUSWIDTH   = 16;
    localparam int FIFO_DEPTH  = 8;
    localparam int CYCLE_LIMIT = 3000;  // six tests of about 300 cycles plus margin
    localparam logic [7:0] INV = 8'h04;  // invert_lemo bit

    logic                 BUS_CLK;
    logic                 RST;
    logic [ABUSWIDTH-1:0] BUS_ADD;
    logic [7:0]           BUS_DATA_IN;
    logic                 BUS_WR;
    logic                 BUS_RD;
    logic                 RJ45_TRIGGER;
    logic                 LEMO_TRIGGER;
    logic                 RJ45_RESET;
    logic                 LEMO_RESET;
    logic                 EXT_VETO;
    logic                 FIFO_READ;
    logic [7:0]           BUS_DATA_OUT;
    logic                 FIFO_EMPTY;
    logic [31:0]          FIFO_DATA;
    logic                 RJ45_ENABLED;
    logic                 TLU_BUSY;

    logic        lemo_idle;       // inactive LEMO level for the current inversion
    logic        busy_forbidden;  // mode without handshake
    int          cycle_cnt;
    logic [7:0]  rd_byte;
    logic [31:0] word;
    logic [31:0] num;
    int          next_num;
    int          base;
    int          reset_cycle;
    int          elapsed;

    tlu_controller #(.ABUSWIDTH(ABUSWIDTH), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .BUS_CLK(BUS_CLK), .RST(RST), .BUS_ADD(BUS_ADD), .BUS_DATA_IN(BUS_DATA_IN),
        .BUS_WR(BUS_WR), .BUS_RD(BUS_RD), .RJ45_TRIGGER(RJ45_TRIGGER),
        .LEMO_TRIGGER(LEMO_TRIGGER), .RJ45_RESET(RJ45_RESET), .LEMO_RESET(LEMO_RESET),
        .EXT_VETO(EXT_VETO), .FIFO_READ(FIFO_READ), .BUS_DATA_OUT(BUS_DATA_OUT),
        .FIFO_EMPTY(FIFO_EMPTY), .FIFO_DATA(FIFO_DATA), .RJ45_ENABLED(RJ45_ENABLED),
        .TLU_BUSY(TLU_BUSY)
    );

    always #50 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1, "stopped on timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // RJ45 lines are held high the whole run
    a_rj45_unplugged: assert property (
        @(posedge BUS_CLK) disable iff (RST) !RJ45_ENABLED
    ) else report_error("RJ45 selected although the connector reads unplugged");

    a_busy_allowed: assert property (
        @(posedge BUS_CLK) disable iff (RST) busy_forbidden |-> !TLU_BUSY
    ) else report_error("TLU_BUSY high outside a handshake mode");

    task automatic write_reg(input int addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= ABUSWIDTH'(addr);
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    // data is registered one cycle after the address
    task automatic read_reg(input int addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= ABUSWIDTH'(addr);
        BUS_RD  <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD <= 1'b0;
        @(negedge BUS_CLK);
        data = BUS_DATA_OUT;
    endtask

    task automatic set_conf(input logic [7:0] value);
        @(posedge BUS_CLK);
        BUS_ADD        <= ABUSWIDTH'(REG_CONF);
        BUS_DATA_IN    <= value;
        BUS_WR         <= 1'b1;
        busy_forbidden <= (value[1:0] == MODE_DISABLED) || (value[1:0] == MODE_NO_HANDSHAKE);
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic pulse_trigger(input int width);
        @(posedge BUS_CLK);
        LEMO_TRIGGER <= !lemo_idle;
        repeat (width) @(posedge BUS_CLK);
        LEMO_TRIGGER <= lemo_idle;
    endtask

    task automatic random_gap();
        repeat (3 + ($urandom % 8)) @(posedge BUS_CLK);
    endtask

    task automatic pop_word(output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge BUS_CLK);
        while (FIFO_EMPTY && (waited < 10))
        begin
            @(negedge BUS_CLK);
            waited++;
        end
        assert (!FIFO_EMPTY) else report_error("no FIFO word within 10 cycles");
        data = FIFO_DATA;
        @(posedge BUS_CLK);
        FIFO_READ <= 1'b1;
        @(posedge BUS_CLK);
        FIFO_READ <= 1'b0;
    endtask

    task automatic expect_number(input int expected);
        logic [31:0] got;
        pop_word(got);
        assert (got === {1'b1, 31'(expected)})
            else report_error($sformatf("FIFO word %h, expected number %0d", got, expected));
    endtask

    task automatic check_no_word(input int cycles);
        repeat (cycles)
        begin
            @(negedge BUS_CLK);
            assert (FIFO_EMPTY) else report_error("unexpected FIFO word");
        end
    endtask

    task automatic wait_busy(input logic level);
        int waited;
        waited = 0;
        @(negedge BUS_CLK);
        while ((TLU_BUSY !== level) && (waited < 10))
        begin
            @(negedge BUS_CLK);
            waited++;
        end
        assert (TLU_BUSY === level)
            else report_error($sformatf("TLU_BUSY did not go to %0b", level));
    endtask

    initial
    begin
        BUS_CLK        = 1'b0;
        RST            = 1'b1;
        BUS_ADD        = '0;
        BUS_DATA_IN    = '0;
        BUS_WR         = 1'b0;
        BUS_RD         = 1'b0;
        RJ45_TRIGGER   = 1'b1;  // unplugged connector
        RJ45_RESET     = 1'b1;
        LEMO_TRIGGER   = 1'b0;
        LEMO_RESET     = 1'b0;
        EXT_VETO       = 1'b0;
        FIFO_READ      = 1'b0;
        lemo_idle      = 1'b0;
        busy_forbidden = 1'b1;
        cycle_cnt      = 0;
        next_num       = 0;
        void'($urandom(32'h8b52));
        repeat (16) @(posedge BUS_CLK);
        RST <= 1'b0;

        // registers in mode 00 so no trigger is accepted
        read_reg(REG_SOFT_RST_VERSION, rd_byte);
        assert (rd_byte === TLU_VERSION) else report_error("wrong version readback");
        set_conf(8'hF8);
        read_reg(REG_CONF, rd_byte);
        assert (rd_byte === 8'hF8) else report_error("configuration readback differs");
        write_reg(REG_SOFT_RST_VERSION, 8'h00);
        read_reg(REG_CONF, rd_byte);
        assert (rd_byte === 8'h00) else report_error("soft reset left configuration set");

        // no handshake with plain LEMO
        set_conf(8'h01);
        for (int i = 0; i < 6; i++)
        begin
            pulse_trigger(2);
            expect_number(next_num);
            next_num++;
            random_gap();
        end

        // switch to inverted LEMO while triggering is disabled
        set_conf(INV);
        @(posedge BUS_CLK);
        LEMO_TRIGGER <= 1'b1;
        lemo_idle = 1'b1;
        repeat (8) @(posedge BUS_CLK);
        set_conf(INV | 8'h01);
        for (int i = 0; i < 3; i++)
        begin
            pulse_trigger(2);
            expect_number(next_num);
            next_num++;
            random_gap();
        end

        // veto blocks triggers until disable_veto lets the same ones through
        @(posedge BUS_CLK);
        EXT_VETO <= 1'b1;
        repeat (5) @(posedge BUS_CLK);
        for (int i = 0; i < 3; i++)
        begin
            pulse_trigger(2);
            check_no_word(12);
        end
        set_conf(INV | 8'h09);
        for (int i = 0; i < 3; i++)
        begin
            pulse_trigger(2);
            expect_number(next_num);
            next_num++;
            random_gap();
        end
        @(posedge BUS_CLK);
        EXT_VETO <= 1'b0;

        // simple handshake where busy covers the whole held trigger
        set_conf(INV | {6'd0, MODE_SIMPLE_HANDSHAKE});
        @(posedge BUS_CLK);
        LEMO_TRIGGER <= !lemo_idle;
        wait_busy(1'b1);
        expect_number(next_num);
        next_num++;
        repeat (20)
        begin
            @(negedge BUS_CLK);
            assert (TLU_BUSY && FIFO_EMPTY)
                else report_error("busy dropped or a word was added during a held trigger");
        end
        @(posedge BUS_CLK);
        LEMO_TRIGGER <= lemo_idle;
        wait_busy(1'b0);
        pulse_trigger(2);
        expect_number(next_num);
        next_num++;
        wait_busy(1'b0);

        // overflow with reads held off
        set_conf(INV | 8'h01);
        base = next_num;
        for (int i = 0; i < FIFO_DEPTH + 3; i++)
        begin
            pulse_trigger(2);
            random_gap();
        end
        repeat (10) @(posedge BUS_CLK);
        read_reg(REG_LOST_CNT, rd_byte);
        assert (rd_byte === 8'd3) else report_error($sformatf("lost count %0d", rd_byte));
        for (int i = 0; i < FIFO_DEPTH; i++)
            expect_number(base + i);
        @(negedge BUS_CLK);
        assert (FIFO_EMPTY) else report_error("FIFO holds more words than its depth");

        // trigger reset followed by a timestamp word
        set_conf(INV | 8'h31);
        @(posedge BUS_CLK);
        LEMO_RESET <= 1'b1;
        reset_cycle = cycle_cnt;
        repeat (2) @(posedge BUS_CLK);
        LEMO_RESET <= 1'b0;
        repeat (10) @(posedge BUS_CLK);
        for (int i = 0; i < 4; i++)
        begin
            read_reg(REG_TRIG_NUM_0 + i, rd_byte);
            num[8*i +: 8] = rd_byte;
        end
        assert (num === 32'd0) else report_error("trigger number not cleared by reset");
        pulse_trigger(2);
        pop_word(word);
        elapsed = cycle_cnt - reset_cycle;
        assert (word[31] && (word[30:0] > 31'd0) && (word[30:0] < 31'(elapsed + 10)))
            else report_error($sformatf("timestamp word %h after %0d cycles", word, elapsed));

        $display("Test OK");
        $finish;
    end

endmodule

/* build.f */
design/tlu_pkg.sv
design/tlu_regs.sv
design/tlu_trigger_input.sv
design/tlu_trigger_fsm.sv
design/tlu_word_fifo.sv
design/tlu_controller.sv
verification/tlu_controller_tb.sv
